// File: common/mem_mon_pkg.sv
/*
 * Shared widths, types and constants of the memory performance monitor.
 * Imported by every RTL block and by the testbench.
 */
package mem_mon_pkg;

    // Observed bus fields
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  req_id_t;

    // Cycle stamp and latency, wraps at 16 bits
    typedef logic [15:0] stamp_t;

    // Statistics
    typedef logic [31:0] count_t;
    typedef logic [31:0] bw_t;
    typedef logic [7:0]  pct_t;

    // Decoded address fields
    typedef logic [1:0]  chan_t;
    typedef logic [3:0]  bank_t;
    typedef logic [14:0] row_t;

    // One tracking slot per request tag
    localparam int NUM_IDS = 16;

    localparam int NUM_CHANNELS      = 4;
    localparam int BANKS_PER_CHANNEL = 16;

    // Low bit of each address field
    localparam int CHAN_LSB = 6;
    localparam int BANK_LSB = 8;
    localparam int ROW_LSB  = 12;

    // Data bytes carried by one response
    localparam int BYTES_PER_RESP = 64;

    // Last bucket collects everything from HIST_BUCKETS-1 upward
    localparam int HIST_BUCKETS = 16;

    // Qualifying windows needed before a flag can rise
    localparam int ANOMALY_RUN_LEN = 10;

    // Bandwidth is reported per thousand cycles
    localparam int BW_SCALE = 1000;

endpackage

// File: hw/latency_tracker/latency_tracker.sv
/*
 * Request-to-response latency tracking by request ID.
 * Gives a per-response latency pulse plus min, max, histogram and totals.
 */
`timescale 1ns/1ps

module latency_tracker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  monitor_enable,
    input  logic                  clear_stats,
    input  logic                  req_fire,
    input  mem_mon_pkg::req_id_t  req_id,
    input  logic                  resp_valid,
    input  logic                  resp_ready,
    input  mem_mon_pkg::req_id_t  resp_id,
    input  mem_mon_pkg::stamp_t   cycle_stamp,
    output logic                  lat_valid,
    output mem_mon_pkg::stamp_t   lat_value,
    output mem_mon_pkg::count_t   total_requests,
    output mem_mon_pkg::count_t   total_responses,
    output mem_mon_pkg::count_t   outstanding,
    output mem_mon_pkg::stamp_t   min_latency,
    output mem_mon_pkg::stamp_t   max_latency,
    output mem_mon_pkg::count_t   latency_histogram [mem_mon_pkg::HIST_BUCKETS]
);
    import mem_mon_pkg::*;

    localparam int BKT_W = $clog2(HIST_BUCKETS);

    stamp_t             stamp_tbl [NUM_IDS];
    logic [NUM_IDS-1:0] busy;
    logic               resp_fire;
    stamp_t             latency;
    logic [BKT_W-1:0]   bucket;

    // Responses to an idle tag are ignored
    assign resp_fire = monitor_enable && resp_valid && resp_ready && busy[resp_id];

    // Stamp difference stays correct across counter wrap
    assign latency = cycle_stamp - stamp_tbl[resp_id];

    assign bucket = (latency < stamp_t'(HIST_BUCKETS - 1)) ? latency[BKT_W-1:0]
                                                          : BKT_W'(HIST_BUCKETS - 1);

    always_ff @(posedge clk) begin
        if (req_fire) begin
            stamp_tbl[req_id] <= cycle_stamp;
        end
    end

    // A tag freed and reissued in the same cycle ends up busy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (resp_fire) begin
                busy[resp_id] <= 1'b0;
            end
            if (req_fire) begin
                busy[req_id] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lat_valid <= 1'b0;
        end else begin
            lat_valid <= resp_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_fire) begin
            lat_value <= latency;
        end
    end

    // Table occupancy follows traffic and survives clear_stats
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + count_t'(req_fire) - count_t'(resp_fire);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            total_requests  <= '0;
            total_responses <= '0;
            min_latency     <= '1;
            max_latency     <= '0;
        end else if (clear_stats) begin
            total_requests  <= '0;
            total_responses <= '0;
            min_latency     <= '1;
            max_latency     <= '0;
        end else begin
            if (req_fire) begin
                total_requests <= total_requests + 1'b1;
            end
            if (resp_fire) begin
                total_responses <= total_responses + 1'b1;
                if (latency < min_latency) begin
                    min_latency <= latency;
                end
                if (latency > max_latency) begin
                    max_latency <= latency;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < HIST_BUCKETS; i++) begin
                latency_histogram[i] <= '0;
            end
        end else if (clear_stats) begin
            for (int i = 0; i < HIST_BUCKETS; i++) begin
                latency_histogram[i] <= '0;
            end
        end else if (resp_fire) begin
            latency_histogram[bucket] <= latency_histogram[bucket] + 1'b1;
        end
    end

    // A tag may only be reused once its response has been seen
    a_id_not_reused: assert property (@(posedge clk) disable iff (!rst_n)
        req_fire |-> !busy[req_id] || (resp_fire && resp_id == req_id));

endmodule

// File: hw/row_buffer/row_buffer_analyzer.sv
/*
 * Row-buffer behaviour of the request stream, with one open row per bank.
 * Counts hits, misses and bank conflicts and derives the hit rate.
 */
`timescale 1ns/1ps

module row_buffer_analyzer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 monitor_enable,
    input  logic                 clear_stats,
    input  logic                 req_fire,
    input  mem_mon_pkg::addr_t   req_addr,
    output mem_mon_pkg::count_t  row_hits,
    output mem_mon_pkg::count_t  row_misses,
    output mem_mon_pkg::count_t  bank_conflicts,
    output mem_mon_pkg::pct_t    hit_rate
);
    import mem_mon_pkg::*;

    localparam int NUM_BANKS = NUM_CHANNELS * BANKS_PER_CHANNEL;
    localparam int IDX_W     = $clog2(NUM_BANKS);

    chan_t                chan;
    bank_t                bank;
    row_t                 row;
    logic [IDX_W-1:0]     bank_idx;
    row_t                 open_row [NUM_BANKS];
    logic [NUM_BANKS-1:0] active;
    logic                 row_hit;
    logic                 access;
    logic [32:0]          accesses;
    logic [39:0]          hits_x100;

    // Address decode
    assign chan     = req_addr[CHAN_LSB +: $bits(chan_t)];
    assign bank     = req_addr[BANK_LSB +: $bits(bank_t)];
    assign row      = req_addr[ROW_LSB +: $bits(row_t)];
    assign bank_idx = {chan, bank};

    // Accepted request while monitoring
    assign access  = monitor_enable && req_fire;
    assign row_hit = active[bank_idx] && (open_row[bank_idx] == row);

    always_ff @(posedge clk) begin
        if (access) begin
            open_row[bank_idx] <= row;
        end
    end

    // Open rows stay put across clear_stats
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= '0;
        end else if (access) begin
            active[bank_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_hits       <= '0;
            row_misses     <= '0;
            bank_conflicts <= '0;
        end else if (clear_stats) begin
            row_hits       <= '0;
            row_misses     <= '0;
            bank_conflicts <= '0;
        end else if (access) begin
            if (row_hit) begin
                row_hits <= row_hits + 1'b1;
            end else begin
                row_misses <= row_misses + 1'b1;
                // Different row already open in this bank
                if (active[bank_idx]) begin
                    bank_conflicts <= bank_conflicts + 1'b1;
                end
            end
        end
    end

    // Truncated percentage, zero before the first access
    always_comb begin
        accesses  = {1'b0, row_hits} + {1'b0, row_misses};
        hits_x100 = 40'(row_hits) * 40'd100;
        if (accesses == '0) begin
            hit_rate = '0;
        end else begin
            hit_rate = pct_t'(hits_x100 / 40'(accesses));
        end
    end

endmodule

// File: hw/window/window_stats.sv
/*
 * Per-window bandwidth and average latency, peak bandwidth and the
 * low-bandwidth and high-latency run flags.
 */
`timescale 1ns/1ps

module window_stats (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 monitor_enable,
    input  logic                 clear_stats,
    input  logic                 req_fire,
    input  logic                 lat_valid,
    input  mem_mon_pkg::stamp_t  lat_value,
    input  mem_mon_pkg::stamp_t  measurement_window,
    input  mem_mon_pkg::bw_t     bw_threshold,
    input  mem_mon_pkg::stamp_t  lat_threshold,
    output mem_mon_pkg::bw_t     current_bandwidth,
    output mem_mon_pkg::bw_t     peak_bandwidth,
    output mem_mon_pkg::stamp_t  current_latency,
    output logic                 bw_anomaly,
    output logic                 lat_anomaly
);
    import mem_mon_pkg::*;

    localparam int RUN_W = $clog2(ANOMALY_RUN_LEN + 1);

    stamp_t           win_cnt;
    logic             win_last;
    count_t           win_resps;
    count_t           win_lat_sum;
    count_t           resps_next;
    count_t           lat_sum_next;
    logic [47:0]      bytes_scaled;
    bw_t              win_bw;
    stamp_t           win_avg_lat;
    logic [RUN_W-1:0] low_bw_run;
    logic [RUN_W-1:0] high_lat_run;

    assign win_last = monitor_enable && (win_cnt >= measurement_window - 1'b1);

    // Totals including this cycle, so the closing cycle still counts
    always_comb begin
        resps_next   = win_resps + count_t'(lat_valid);
        lat_sum_next = win_lat_sum + (lat_valid ? count_t'(lat_value) : '0);
        bytes_scaled = 48'(resps_next) * 48'(BYTES_PER_RESP * BW_SCALE);
        win_bw       = (measurement_window == '0) ? '0
                                                  : bw_t'(bytes_scaled / measurement_window);
        win_avg_lat  = (resps_next == '0) ? '0 : stamp_t'(lat_sum_next / resps_next);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_cnt     <= '0;
            win_resps   <= '0;
            win_lat_sum <= '0;
        end else if (win_last) begin
            win_cnt     <= '0;
            win_resps   <= '0;
            win_lat_sum <= '0;
        end else begin
            if (monitor_enable) begin
                win_cnt <= win_cnt + 1'b1;
            end
            win_resps   <= resps_next;
            win_lat_sum <= lat_sum_next;
        end
    end

    // Run counters stop at the limit, the flag then holds
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            current_bandwidth <= '0;
            current_latency   <= '0;
            low_bw_run        <= '0;
            high_lat_run      <= '0;
            bw_anomaly        <= 1'b0;
            lat_anomaly       <= 1'b0;
        end else if (win_last) begin
            current_bandwidth <= win_bw;
            current_latency   <= win_avg_lat;
            if (win_bw < bw_threshold) begin
                if (low_bw_run != RUN_W'(ANOMALY_RUN_LEN)) begin
                    low_bw_run <= low_bw_run + 1'b1;
                end else begin
                    bw_anomaly <= 1'b1;
                end
            end else begin
                low_bw_run <= '0;
                bw_anomaly <= 1'b0;
            end
            if (win_avg_lat > lat_threshold) begin
                if (high_lat_run != RUN_W'(ANOMALY_RUN_LEN)) begin
                    high_lat_run <= high_lat_run + 1'b1;
                end else begin
                    lat_anomaly <= 1'b1;
                end
            end else begin
                high_lat_run <= '0;
                lat_anomaly  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            peak_bandwidth <= '0;
        end else if (clear_stats) begin
            peak_bandwidth <= '0;
        end else if (win_last && win_bw > peak_bandwidth) begin
            peak_bandwidth <= win_bw;
        end
    end

    a_window_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        monitor_enable |-> measurement_window != '0);

endmodule

// File: hw/mem_monitor_top.sv
/*
 * Passive performance monitor for one memory controller request/response port.
 * Holds the enabled-cycle stamp and feeds the three analysis blocks.
 */
`timescale 1ns/1ps

module mem_monitor_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 monitor_enable,
    input  logic                 clear_stats,
    input  logic                 req_valid,
    input  logic                 req_ready,
    input  mem_mon_pkg::addr_t   req_addr,
    input  mem_mon_pkg::req_id_t req_id,
    input  logic                 resp_valid,
    input  logic                 resp_ready,
    input  mem_mon_pkg::req_id_t resp_id,
    input  mem_mon_pkg::stamp_t  measurement_window,
    input  mem_mon_pkg::bw_t     bw_threshold,
    input  mem_mon_pkg::stamp_t  lat_threshold,
    output mem_mon_pkg::count_t  total_requests,
    output mem_mon_pkg::count_t  total_responses,
    output mem_mon_pkg::count_t  outstanding,
    output mem_mon_pkg::stamp_t  min_latency,
    output mem_mon_pkg::stamp_t  max_latency,
    output mem_mon_pkg::count_t  latency_histogram [mem_mon_pkg::HIST_BUCKETS],
    output mem_mon_pkg::count_t  row_hits,
    output mem_mon_pkg::count_t  row_misses,
    output mem_mon_pkg::count_t  bank_conflicts,
    output mem_mon_pkg::pct_t    hit_rate,
    output mem_mon_pkg::bw_t     current_bandwidth,
    output mem_mon_pkg::bw_t     peak_bandwidth,
    output mem_mon_pkg::stamp_t  current_latency,
    output logic                 bw_anomaly,
    output logic                 lat_anomaly
);
    import mem_mon_pkg::*;

    stamp_t cycle_stamp;
    logic   req_fire;
    logic   lat_valid;
    stamp_t lat_value;

    assign req_fire = monitor_enable && req_valid && req_ready;

    // Time base in enabled cycles only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_stamp <= '0;
        end else if (monitor_enable) begin
            cycle_stamp <= cycle_stamp + 1'b1;
        end
    end

    latency_tracker u_lat (
        .clk               (clk),
        .rst_n             (rst_n),
        .monitor_enable    (monitor_enable),
        .clear_stats       (clear_stats),
        .req_fire          (req_fire),
        .req_id            (req_id),
        .resp_valid        (resp_valid),
        .resp_ready        (resp_ready),
        .resp_id           (resp_id),
        .cycle_stamp       (cycle_stamp),
        .lat_valid         (lat_valid),
        .lat_value         (lat_value),
        .total_requests    (total_requests),
        .total_responses   (total_responses),
        .outstanding       (outstanding),
        .min_latency       (min_latency),
        .max_latency       (max_latency),
        .latency_histogram (latency_histogram)
    );

    row_buffer_analyzer u_rba (
        .clk            (clk),
        .rst_n          (rst_n),
        .monitor_enable (monitor_enable),
        .clear_stats    (clear_stats),
        .req_fire       (req_fire),
        .req_addr       (req_addr),
        .row_hits       (row_hits),
        .row_misses     (row_misses),
        .bank_conflicts (bank_conflicts),
        .hit_rate       (hit_rate)
    );

    window_stats u_win (
        .clk                (clk),
        .rst_n              (rst_n),
        .monitor_enable     (monitor_enable),
        .clear_stats        (clear_stats),
        .req_fire           (req_fire),
        .lat_valid          (lat_valid),
        .lat_value          (lat_value),
        .measurement_window (measurement_window),
        .bw_threshold       (bw_threshold),
        .lat_threshold      (lat_threshold),
        .current_bandwidth  (current_bandwidth),
        .peak_bandwidth     (peak_bandwidth),
        .current_latency    (current_latency),
        .bw_anomaly         (bw_anomaly),
        .lat_anomaly        (lat_anomaly)
    );

endmodule

// File: verification/mem_monitor_ref.svh
/*
 * Reference model functions for the memory monitor testbench.
 * Included inside the testbench module after the package import.
 */
`ifndef MEM_MONITOR_REF_SVH
`define MEM_MONITOR_REF_SVH

// Histogram bucket of one latency, last bucket saturates
function automatic int lat_bucket(input stamp_t lat);
    if (lat < stamp_t'(HIST_BUCKETS - 1)) begin
        return int'(lat);
    end
    return HIST_BUCKETS - 1;
endfunction

// Flat bank number, channel major
function automatic int bank_index(input addr_t addr);
    chan_t c;
    bank_t b;
    c = chan_t'(addr >> CHAN_LSB);
    b = bank_t'(addr >> BANK_LSB);
    return int'(c) * BANKS_PER_CHANNEL + int'(b);
endfunction

function automatic row_t row_of(input addr_t addr);
    return row_t'(addr >> ROW_LSB);
endfunction

// Bytes per thousand cycles over one window
function automatic bw_t window_bw(input longint resps, input longint win_len);
    return bw_t'(resps * BYTES_PER_RESP * BW_SCALE / win_len);
endfunction

function automatic stamp_t avg_latency(input longint lat_sum, input longint resps);
    if (resps == 0) begin
        return '0;
    end
    return stamp_t'(lat_sum / resps);
endfunction

// Truncated hit percentage
function automatic pct_t hit_pct(input longint hits, input longint misses);
    if (hits + misses == 0) begin
        return '0;
    end
    return pct_t'(hits * 100 / (hits + misses));
endfunction

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
endfunction

`endif

// File: verification/mem_monitor_tb.sv
/*
 * Testbench for the memory monitor: random and directed traffic against
 * a reference model, checked on the falling clock edge.
 */
`timescale 1ns/1ps

module mem_monitor_tb;
    import mem_mon_pkg::*;
    `include "mem_monitor_ref.svh"

    logic clk, rst_n, monitor_enable, clear_stats;
    logic req_valid, req_ready, resp_valid, resp_ready;
    addr_t req_addr;
    req_id_t req_id, resp_id;
    stamp_t measurement_window, lat_threshold;
    bw_t bw_threshold;
    count_t total_requests, total_responses, outstanding;
    stamp_t min_latency, max_latency, current_latency;
    count_t latency_histogram [HIST_BUCKETS];
    count_t row_hits, row_misses, bank_conflicts;
    pct_t hit_rate;
    bw_t current_bandwidth, peak_bandwidth;
    logic bw_anomaly, lat_anomaly;

    // Reference model state
    stamp_t m_stamp, m_min, m_max;
    stamp_t m_tbl [NUM_IDS];
    logic [NUM_IDS-1:0] m_busy;
    longint m_reqs, m_resps, m_hits, m_misses, m_conf;
    longint m_hist [HIST_BUCKETS];
    row_t m_row [64];
    logic [63:0] m_active;
    stamp_t exp_lat [$];
    bw_t exp_bw, m_peak;
    stamp_t exp_avg;
    int low_run, high_run;
    bit have_prev;

    logic [31:0] lfsr = 32'h76de421d;
    int errors, checks, tests, failed_tests;

    mem_monitor_top dut0 (.*);

    always #2 clk = ~clk;

    initial begin
        #2_000_000;
        $display("timeout: simulation did not reach its end");
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    task automatic check_val(input string name, input longint got, input longint exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // Compares each latency pulse with the oldest expected value
    always @(negedge clk) begin
        if (rst_n && dut0.lat_valid) begin
            assert (exp_lat.size() != 0) else begin
                errors++;
                $display("lat_valid pulsed at %0t ns with no response expected", $time);
            end
            if (exp_lat.size() != 0) begin
                check_val("lat_value", dut0.lat_value, exp_lat.pop_front());
            end
        end
    end

    task automatic clear_model();
        m_reqs = 0;
        m_resps = 0;
        m_min = '1;
        m_max = '0;
        m_hits = 0;
        m_misses = 0;
        m_conf = 0;
        m_peak = '0;
        for (int i = 0; i < HIST_BUCKETS; i++) begin
            m_hist[i] = 0;
        end
    endtask

    // One bus cycle, with the model updated for what the DUT will see
    task automatic drive(input logic en, input logic clr, input logic rv, input req_id_t rid,
                         input addr_t addr, input logic sv, input req_id_t sid);
        stamp_t lat;
        int b;
        @(posedge clk);
        monitor_enable <= en;
        clear_stats    <= clr;
        req_valid      <= rv;
        req_id         <= rid;
        req_addr       <= addr;
        resp_valid     <= sv;
        resp_id        <= sid;
        if (clr) begin
            clear_model();
        end
        if (en) begin
            if (sv && m_busy[sid]) begin
                lat = m_stamp - m_tbl[sid];
                exp_lat.push_back(lat);
                m_resps++;
                m_hist[lat_bucket(lat)]++;
                if (lat < m_min) m_min = lat;
                if (lat > m_max) m_max = lat;
                m_busy[sid] = 1'b0;
            end
            if (rv) begin
                m_busy[rid] = 1'b1;
                m_tbl[rid] = m_stamp;
                m_reqs++;
                b = bank_index(addr);
                if (m_active[b] && m_row[b] == row_of(addr)) begin
                    m_hits++;
                end else begin
                    m_misses++;
                    if (m_active[b]) m_conf++;
                end
                m_active[b] = 1'b1;
                m_row[b] = row_of(addr);
            end
            m_stamp++;
        end
    endtask

    task automatic reset_dut(input stamp_t win, input bw_t bwt, input stamp_t latt);
        @(posedge clk);
        rst_n <= 1'b0;
        monitor_enable <= 1'b0;
        req_valid <= 1'b0;
        resp_valid <= 1'b0;
        measurement_window <= win;
        bw_threshold <= bwt;
        lat_threshold <= latt;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        m_stamp = '0;
        m_busy = '0;
        m_active = '0;
        exp_lat.delete();
        clear_model();
        low_run = 0;
        high_run = 0;
        have_prev = 0;
    endtask

    // Idle cycles until every expected latency pulse has been seen
    task automatic wait_results();
        int t;
        t = 0;
        while (exp_lat.size() != 0 && t < 20) begin
            drive(1, 0, 0, 0, 0, 0, 0);
            @(negedge clk);
            t++;
        end
        drive(1, 0, 0, 0, 0, 0, 0);
        @(negedge clk);
        assert (exp_lat.size() == 0) else begin
            errors++;
            $display("timeout: %0d latency results never arrived", exp_lat.size());
        end
    endtask

    task automatic check_stats();
        check_val("total_requests", total_requests, m_reqs);
        check_val("total_responses", total_responses, m_resps);
        check_val("outstanding", outstanding, $countones(m_busy));
        check_val("min_latency", min_latency, m_min);
        check_val("max_latency", max_latency, m_max);
        for (int i = 0; i < HIST_BUCKETS; i++) begin
            check_val($sformatf("latency_histogram[%0d]", i), latency_histogram[i], m_hist[i]);
        end
        check_val("row_hits", row_hits, m_hits);
        check_val("row_misses", row_misses, m_misses);
        check_val("bank_conflicts", bank_conflicts, m_conf);
        check_val("hit_rate", hit_rate, hit_pct(m_hits, m_misses));
    endtask

    task automatic check_window();
        check_val("current_bandwidth", current_bandwidth, exp_bw);
        check_val("current_latency", current_latency, exp_avg);
        check_val("peak_bandwidth", peak_bandwidth, m_peak);
        check_val("bw_anomaly", bw_anomaly, low_run > ANOMALY_RUN_LEN);
        check_val("lat_anomaly", lat_anomaly, high_run > ANOMALY_RUN_LEN);
    endtask

    // n requests from cycle 2, each answered d cycles later, window edges idle
    task automatic run_window(input int n, input int d);
        for (int c = 0; c < measurement_window; c++) begin
            drive(1, 0, c >= 2 && c < 2 + n, req_id_t'(c - 2), '0,
                  c >= 2 + d && c < 2 + n + d, req_id_t'(c - 2 - d));
            if (c == 0 && have_prev) begin
                @(negedge clk);
                check_window();
            end
        end
        exp_bw = window_bw(n, measurement_window);
        exp_avg = avg_latency(n * d, n);
        if (exp_bw > m_peak) m_peak = exp_bw;
        low_run = (exp_bw < bw_threshold) ? low_run + 1 : 0;
        high_run = (exp_avg > lat_threshold) ? high_run + 1 : 0;
        have_prev = 1;
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        if (errors != errs_before) failed_tests++;
        $display("test %s done, %0d errors", name, errors - errs_before);
    endtask

    initial begin
        int e;
        logic rv, sv;
        req_id_t rid, sid;
        addr_t addr;
        bw_t snap_bw, snap_peak;
        stamp_t snap_lat;
        clk = 1'b0;
        rst_n = 1'b0;
        monitor_enable = 1'b0;
        clear_stats = 1'b0;
        req_valid = 1'b0;
        req_ready = 1'b1;
        resp_valid = 1'b0;
        resp_ready = 1'b1;
        req_addr = '0;
        req_id = '0;
        resp_id = '0;
        measurement_window = 16'd1000;
        bw_threshold = '0;
        lat_threshold = '1;

        e = errors;
        reset_dut(16'd1000, '0, '1);
        @(negedge clk);
        check_stats();
        exp_bw = '0;
        exp_avg = '0;
        check_window();
        end_test("reset_state", e);

        // Random tags, delays and a small row/bank set
        e = errors;
        for (int i = 0; i < 400; i++) begin
            rv = rand_bits(1);
            rid = rand_bits(4);
            sv = rand_bits(1);
            sid = rand_bits(4);
            if (m_busy[rid] && !(sv && sid == rid && m_busy[sid])) rv = 1'b0;
            addr = (rand_bits(2) << ROW_LSB) | (rand_bits(1) << BANK_LSB)
                 | (rand_bits(1) << CHAN_LSB);
            drive(1, 0, rv, rid, addr, sv, sid);
        end
        wait_results();
        check_stats();
        end_test("random_latency_and_rows", e);

        // Long enough that an ungated window counter would close a window
        e = errors;
        snap_bw = current_bandwidth;
        snap_peak = peak_bandwidth;
        snap_lat = current_latency;
        for (int i = 0; i < measurement_window; i++) begin
            drive(0, 0, 1, rand_bits(4), rand_bits(32), 1, rand_bits(4));
        end
        drive(0, 0, 0, 0, 0, 0, 0);
        @(negedge clk);
        check_stats();
        check_val("current_bandwidth", current_bandwidth, snap_bw);
        check_val("peak_bandwidth", peak_bandwidth, snap_peak);
        check_val("current_latency", current_latency, snap_lat);
        end_test("gating", e);

        e = errors;
        reset_dut(16'd20, '0, '1);
        for (int k = 0; k < 8; k++) begin
            run_window(rand_bits(3) % 7, rand_bits(3) % 6 + 1);
        end
        drive(1, 0, 0, 0, 0, 0, 0);
        @(negedge clk);
        check_window();
        end_test("window_results", e);

        // Peak and totals are nonzero here
        e = errors;
        drive(1, 1, 0, 0, 0, 0, 0);
        drive(1, 0, 0, 0, 0, 0, 0);
        @(negedge clk);
        check_stats();
        check_val("peak_bandwidth", peak_bandwidth, 0);
        end_test("clear_stats", e);

        // 3200 is low against 4000, latency 5 is high against 3
        e = errors;
        reset_dut(16'd20, 32'd4000, 16'd3);
        for (int k = 0; k < 12; k++) begin
            run_window(1, 5);
        end
        run_window(2, 1);
        run_window(2, 1);
        drive(1, 0, 0, 0, 0, 0, 0);
        @(negedge clk);
        check_window();
        end_test("anomaly_flags", e);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verification
common/mem_mon_pkg.sv
hw/latency_tracker/latency_tracker.sv
hw/row_buffer/row_buffer_analyzer.sv
hw/window/window_stats.sv
hw/mem_monitor_top.sv
verification/mem_monitor_tb.sv
